/* dbg_pkg.sv */
package dbg_pkg;

  // Stage index order is spmm, dmvm, sm, aggr (0 to 3).
  localparam int DBG_NUM_STAGES = 4;
  localparam int DBG_CNT_W      = 8;
  localparam int DBG_FLAGS_W    = 2 * DBG_NUM_STAGES;
  localparam int DBG_COUNTS_W   = DBG_NUM_STAGES * DBG_CNT_W;

  // Memory stream widths.
  localparam int DBG_WH_ADDR_W   = 14;
  localparam int DBG_PE_DATA_W   = 12;
  localparam int DBG_FEAT_ADDR_W = 16;
  localparam int DBG_FEAT_DATA_W = 32;

  // APB slave port.
  localparam int DBG_APB_ADDR_W = 8;
  localparam int DBG_APB_DATA_W = 32;

  // Register map, byte offsets.
  localparam logic [DBG_APB_ADDR_W-1:0] REG_ID         = 8'h00;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_FLAGS      = 8'h04;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_CTRL       = 8'h08;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_WH_MATCH   = 8'h0C;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_FEAT_MATCH = 8'h10;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_HITS       = 8'h14;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_WH_DATA    = 8'h18;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_FEAT_DATA  = 8'h1C;
  localparam logic [DBG_APB_ADDR_W-1:0] REG_COUNTS     = 8'h20;

  // Bit positions in REG_CTRL and REG_HITS.
  localparam int CTRL_CLEAR_BIT = 0;
  localparam int HITS_WH_BIT    = 0;
  localparam int HITS_FEAT_BIT  = 1;

  // Fixed identification word returned by REG_ID.
  localparam logic [DBG_APB_DATA_W-1:0] DBG_ID_VALUE = 32'h6A7D_0B51;

endpackage

/* stage_monitor.sv */
`timescale 1ns/1ns

module stage_monitor (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             clear_i,
  input  logic [dbg_pkg::DBG_NUM_STAGES-1:0] vld_i,
  input  logic [dbg_pkg::DBG_NUM_STAGES-1:0] rdy_i,
  output logic [dbg_pkg::DBG_FLAGS_W-1:0]    flags_o,
  output logic [dbg_pkg::DBG_COUNTS_W-1:0]   counts_o
);

  logic [dbg_pkg::DBG_NUM_STAGES-1:0] vld_seen_q;
  logic [dbg_pkg::DBG_NUM_STAGES-1:0] rdy_seen_q;

  // Sticky flags. A clear in the same cycle wins over a new event.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_seen_q <= '0;
      rdy_seen_q <= '0;
    end else if (clear_i) begin
      vld_seen_q <= '0;
      rdy_seen_q <= '0;
    end else begin
      vld_seen_q <= vld_seen_q | vld_i;
      rdy_seen_q <= rdy_seen_q | rdy_i;
    end
  end

  for (genvar i = 0; i < dbg_pkg::DBG_NUM_STAGES; i++) begin : g_stage
    // Stage 0 lands in the top flag pair so that spmm reads MSB first.
    localparam int FLAG_RDY = 2 * (dbg_pkg::DBG_NUM_STAGES - 1 - i);

    logic [dbg_pkg::DBG_CNT_W-1:0] cnt_q;
    logic                          handshake;

    assign handshake = vld_i[i] & rdy_i[i];

    // Saturating count of completed transfers.
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        cnt_q <= '0;
      end else if (clear_i) begin
        cnt_q <= '0;
      end else if (handshake && (cnt_q != '1)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end

    assign flags_o[FLAG_RDY + 1] = vld_seen_q[i];
    assign flags_o[FLAG_RDY]     = rdy_seen_q[i];
    assign counts_o[i*dbg_pkg::DBG_CNT_W +: dbg_pkg::DBG_CNT_W] = cnt_q;
  end

endmodule

/* sample_capture.sv */
`timescale 1ns/1ns

module sample_capture #(
  parameter type addr_t = logic [7:0],
  parameter type data_t = logic [7:0]
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clear_i,
  input  logic  strobe_i,
  input  addr_t addr_i,
  input  data_t data_i,
  input  addr_t match_i,
  output data_t data_o,
  output logic  hit_o
);

  logic  match;
  data_t data_q;
  logic  hit_q;

  assign match = strobe_i && (addr_i == match_i);

  // The last matching beat is kept, earlier ones are overwritten.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      data_q <= '0;
      hit_q  <= 1'b0;
    end else if (clear_i) begin
      data_q <= '0;
      hit_q  <= 1'b0;
    end else if (match) begin
      data_q <= data_i;
      hit_q  <= 1'b1;
    end
  end

  assign data_o = data_q;
  assign hit_o  = hit_q;

endmodule

/* dbg_apb_regs.sv */
`timescale 1ns/1ns

module dbg_apb_regs (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [dbg_pkg::DBG_APB_ADDR_W-1:0]  paddr_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [dbg_pkg::DBG_APB_DATA_W-1:0]  pwdata_i,
  output logic [dbg_pkg::DBG_APB_DATA_W-1:0]  prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  input  logic [dbg_pkg::DBG_FLAGS_W-1:0]     flags_i,
  input  logic [dbg_pkg::DBG_COUNTS_W-1:0]    counts_i,
  input  logic [dbg_pkg::DBG_PE_DATA_W-1:0]   wh_data_i,
  input  logic                               wh_hit_i,
  input  logic [dbg_pkg::DBG_FEAT_DATA_W-1:0] feat_data_i,
  input  logic                               feat_hit_i,
  output logic                               clear_o,
  output logic [dbg_pkg::DBG_WH_ADDR_W-1:0]   wh_match_o,
  output logic [dbg_pkg::DBG_FEAT_ADDR_W-1:0] feat_match_o
);

  logic                               access;
  logic                               mapped;
  logic                               writable;
  logic                               wr_ok;
  logic [dbg_pkg::DBG_APB_DATA_W-1:0]  rdata;
  logic                               clear_q;
  logic [dbg_pkg::DBG_WH_ADDR_W-1:0]   wh_match_q;
  logic [dbg_pkg::DBG_FEAT_ADDR_W-1:0] feat_match_q;

  assign access = psel_i & penable_i;  // No wait states, so every access cycle completes.

  always_comb begin
    mapped   = 1'b1;
    writable = 1'b0;
    case (paddr_i)
      dbg_pkg::REG_ID, dbg_pkg::REG_FLAGS, dbg_pkg::REG_HITS,
      dbg_pkg::REG_WH_DATA, dbg_pkg::REG_FEAT_DATA, dbg_pkg::REG_COUNTS: writable = 1'b0;
      dbg_pkg::REG_CTRL, dbg_pkg::REG_WH_MATCH, dbg_pkg::REG_FEAT_MATCH: writable = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign wr_ok = access && pwrite_i && writable;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_match_q   <= '0;
      feat_match_q <= '0;
      clear_q      <= 1'b0;
    end else begin
      // The clear request becomes a one-cycle pulse after the write.
      clear_q <= wr_ok && (paddr_i == dbg_pkg::REG_CTRL) && pwdata_i[dbg_pkg::CTRL_CLEAR_BIT];
      if (wr_ok && (paddr_i == dbg_pkg::REG_WH_MATCH)) begin
        wh_match_q <= pwdata_i[dbg_pkg::DBG_WH_ADDR_W-1:0];
      end
      if (wr_ok && (paddr_i == dbg_pkg::REG_FEAT_MATCH)) begin
        feat_match_q <= pwdata_i[dbg_pkg::DBG_FEAT_ADDR_W-1:0];
      end
    end
  end

  // Unmapped offsets and the write-only CTRL register read as zero.
  always_comb begin
    rdata = '0;
    case (paddr_i)
      dbg_pkg::REG_ID:         rdata = dbg_pkg::DBG_ID_VALUE;
      dbg_pkg::REG_FLAGS:      rdata[dbg_pkg::DBG_FLAGS_W-1:0] = flags_i;
      dbg_pkg::REG_WH_MATCH:   rdata[dbg_pkg::DBG_WH_ADDR_W-1:0] = wh_match_q;
      dbg_pkg::REG_FEAT_MATCH: rdata[dbg_pkg::DBG_FEAT_ADDR_W-1:0] = feat_match_q;
      dbg_pkg::REG_HITS: begin
        rdata[dbg_pkg::HITS_WH_BIT]   = wh_hit_i;
        rdata[dbg_pkg::HITS_FEAT_BIT] = feat_hit_i;
      end
      dbg_pkg::REG_WH_DATA:    rdata[dbg_pkg::DBG_PE_DATA_W-1:0] = wh_data_i;
      dbg_pkg::REG_FEAT_DATA:  rdata[dbg_pkg::DBG_FEAT_DATA_W-1:0] = feat_data_i;
      dbg_pkg::REG_COUNTS:     rdata[dbg_pkg::DBG_COUNTS_W-1:0] = counts_i;
      default:                 rdata = '0;
    endcase
  end

  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;
  assign pready_o  = 1'b1;
  assign pslverr_o = access && (!mapped || (pwrite_i && !writable));

  assign clear_o      = clear_q;
  assign wh_match_o   = wh_match_q;
  assign feat_match_o = feat_match_q;

endmodule

/* dbg_top.sv */
`timescale 1ns/1ns

module dbg_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [dbg_pkg::DBG_APB_ADDR_W-1:0]  paddr_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [dbg_pkg::DBG_APB_DATA_W-1:0]  pwdata_i,
  output logic [dbg_pkg::DBG_APB_DATA_W-1:0]  prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  input  logic                               spmm_vld_i,
  input  logic                               spmm_rdy_i,
  input  logic                               dmvm_vld_i,
  input  logic                               dmvm_rdy_i,
  input  logic                               sm_vld_i,
  input  logic                               sm_rdy_i,
  input  logic                               aggr_vld_i,
  input  logic                               aggr_rdy_i,
  input  logic [dbg_pkg::DBG_WH_ADDR_W-1:0]   wh_addr_i,
  input  logic [dbg_pkg::DBG_PE_DATA_W-1:0]   pe_data_i,
  input  logic [dbg_pkg::DBG_FEAT_ADDR_W-1:0] feat_addr_i,
  input  logic [dbg_pkg::DBG_FEAT_DATA_W-1:0] feat_data_i,
  input  logic                               feat_en_i
);

  logic                               clear;
  logic [dbg_pkg::DBG_FLAGS_W-1:0]     flags;
  logic [dbg_pkg::DBG_COUNTS_W-1:0]    counts;
  logic [dbg_pkg::DBG_WH_ADDR_W-1:0]   wh_match;
  logic [dbg_pkg::DBG_FEAT_ADDR_W-1:0] feat_match;
  logic [dbg_pkg::DBG_PE_DATA_W-1:0]   wh_data;
  logic                               wh_hit;
  logic [dbg_pkg::DBG_FEAT_DATA_W-1:0] feat_data;
  logic                               feat_hit;

  stage_monitor u_stage_monitor (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear_i  (clear),
    .vld_i    ({aggr_vld_i, sm_vld_i, dmvm_vld_i, spmm_vld_i}),
    .rdy_i    ({aggr_rdy_i, sm_rdy_i, dmvm_rdy_i, spmm_rdy_i}),
    .flags_o  (flags),
    .counts_o (counts)
  );

  // PE results are taken whenever the spmm stage accepts.
  sample_capture #(
    .addr_t (logic [dbg_pkg::DBG_WH_ADDR_W-1:0]),
    .data_t (logic [dbg_pkg::DBG_PE_DATA_W-1:0])
  ) u_wh_capture (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear_i  (clear),
    .strobe_i (spmm_rdy_i),
    .addr_i   (wh_addr_i),
    .data_i   (pe_data_i),
    .match_i  (wh_match),
    .data_o   (wh_data),
    .hit_o    (wh_hit)
  );

  sample_capture #(
    .addr_t (logic [dbg_pkg::DBG_FEAT_ADDR_W-1:0]),
    .data_t (logic [dbg_pkg::DBG_FEAT_DATA_W-1:0])
  ) u_feat_capture (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear_i  (clear),
    .strobe_i (feat_en_i),
    .addr_i   (feat_addr_i),
    .data_i   (feat_data_i),
    .match_i  (feat_match),
    .data_o   (feat_data),
    .hit_o    (feat_hit)
  );

  dbg_apb_regs u_apb_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .flags_i      (flags),
    .counts_i     (counts),
    .wh_data_i    (wh_data),
    .wh_hit_i     (wh_hit),
    .feat_data_i  (feat_data),
    .feat_hit_i   (feat_hit),
    .clear_o      (clear),
    .wh_match_o   (wh_match),
    .feat_match_o (feat_match)
  );

endmodule

/* dbg_checker.sv */
`timescale 1ns/1ns

module dbg_checker (
  input logic                              clk,
  input logic                              rst_n,
  input logic                              psel_i,
  input logic                              penable_i,
  input logic                              pwrite_i,
  input logic [dbg_pkg::DBG_APB_DATA_W-1:0] prdata_o,
  input logic                              pready_o,
  input logic                              pslverr_o
);

  int fails = 0;  // Number of failed assertions.

  a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready_o)
    else begin
      fails++;
      $error("pready_o dropped low, the slave must never insert wait states");
    end

  // An error response only belongs in the access phase.
  a_pslverr_access: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr_o |-> (psel_i && penable_i))
    else begin
      fails++;
      $error("pslverr_o high outside an access cycle");
    end

  a_prdata_known: assert property (@(posedge clk) disable iff (!rst_n)
    (psel_i && penable_i && !pwrite_i) |-> !$isunknown(prdata_o))
    else begin
      fails++;
      $error("prdata_o has unknown bits during a read access");
    end

endmodule

/* dbg_scoreboard.sv */
`timescale 1ns/1ns

module dbg_scoreboard (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  input  logic [31:0] prdata_i,
  input  logic        pslverr_i,
  input  logic [7:0]  stage_lines_i,  // spmm vld, spmm rdy, ... aggr rdy, MSB first.
  input  logic [13:0] wh_addr_i,
  input  logic [11:0] pe_data_i,
  input  logic [15:0] feat_addr_i,
  input  logic [31:0] feat_data_i,
  input  logic        feat_en_i,
  output int          checks_o,
  output int          errors_o
);

  logic [7:0]  flags_m;
  logic [7:0]  cnt_m [4];
  logic [11:0] wh_data_m;
  logic [31:0] feat_data_m;
  logic        wh_hit_m;
  logic        feat_hit_m;
  logic [13:0] wh_match_m;
  logic [15:0] feat_match_m;
  logic        clear_m;  // Clear pulse that acts at the next edge.

  initial begin
    checks_o = 0;
    errors_o = 0;
  end

  // Expected {pslverr, prdata} of a read at the given offset.
  function automatic logic [32:0] ref_read(input logic [7:0] offset);
    logic [32:0] r;
    r = '0;
    case (offset)
      dbg_pkg::REG_ID:         r[31:0] = dbg_pkg::DBG_ID_VALUE;
      dbg_pkg::REG_FLAGS:      r[7:0] = flags_m;
      dbg_pkg::REG_CTRL:       r = '0;
      dbg_pkg::REG_WH_MATCH:   r[13:0] = wh_match_m;
      dbg_pkg::REG_FEAT_MATCH: r[15:0] = feat_match_m;
      dbg_pkg::REG_HITS:       r[1:0] = {feat_hit_m, wh_hit_m};
      dbg_pkg::REG_WH_DATA:    r[11:0] = wh_data_m;
      dbg_pkg::REG_FEAT_DATA:  r[31:0] = feat_data_m;
      dbg_pkg::REG_COUNTS:     r[31:0] = {cnt_m[3], cnt_m[2], cnt_m[1], cnt_m[0]};
      default:                 r[32] = 1'b1;
    endcase
    return r;
  endfunction

  function automatic logic write_err(input logic [7:0] offset);
    return !(offset inside {dbg_pkg::REG_CTRL, dbg_pkg::REG_WH_MATCH, dbg_pkg::REG_FEAT_MATCH});
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks_o++;
    if (got !== exp) begin
      errors_o++;
      $display("FAIL t=%0t %s: got 0x%08h, expected 0x%08h (paddr 0x%02h)",
               $time, name, got, exp, paddr_i);
    end
  endtask

  task automatic clear_state();
    flags_m     = '0;
    cnt_m       = '{default: '0};
    wh_data_m   = '0;
    feat_data_m = '0;
    wh_hit_m    = 1'b0;
    feat_hit_m  = 1'b0;
  endtask

  // Inputs change 5 ns after the rising edge, so mid-cycle they hold the values of the next edge.
  always @(negedge clk) begin : model
    logic [32:0] exp;
    logic        acc;
    logic        clear_next;
    logic [3:0]  hs;
    acc = psel_i && penable_i;
    hs  = {stage_lines_i[1] & stage_lines_i[0], stage_lines_i[3] & stage_lines_i[2],
           stage_lines_i[5] & stage_lines_i[4], stage_lines_i[7] & stage_lines_i[6]};
    if (!rst_n) begin
      clear_state();
      wh_match_m   = '0;
      feat_match_m = '0;
      clear_m      = 1'b0;
    end else begin
      if (acc) begin
        exp = ref_read(paddr_i);
        if (!pwrite_i) begin
          compare("prdata_o", prdata_i, exp[31:0]);
          compare("pslverr_o", 32'(pslverr_i), 32'(exp[32]));
        end else begin
          compare("pslverr_o", 32'(pslverr_i), 32'(write_err(paddr_i)));
        end
      end
      clear_next = acc && pwrite_i && (paddr_i == dbg_pkg::REG_CTRL) && pwdata_i[0];
      if (clear_m) begin
        clear_state();  // Events in this cycle are lost.
      end else begin
        flags_m = flags_m | stage_lines_i;
        for (int i = 0; i < 4; i++) begin
          if (hs[i] && (cnt_m[i] != 8'hFF)) begin
            cnt_m[i] = cnt_m[i] + 8'd1;
          end
        end
        if (stage_lines_i[6] && (wh_addr_i == wh_match_m)) begin
          wh_data_m = pe_data_i;
          wh_hit_m  = 1'b1;
        end
        if (feat_en_i && (feat_addr_i == feat_match_m)) begin
          feat_data_m = feat_data_i;
          feat_hit_m  = 1'b1;
        end
      end
      if (acc && pwrite_i && (paddr_i == dbg_pkg::REG_WH_MATCH)) begin
        wh_match_m = pwdata_i[13:0];
      end
      if (acc && pwrite_i && (paddr_i == dbg_pkg::REG_FEAT_MATCH)) begin
        feat_match_m = pwdata_i[15:0];
      end
      clear_m = clear_next;
    end
  end

endmodule

/* dbg_tb.sv */
`timescale 1ns/1ns

module dbg_tb;

  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DELAY    = 5;
  localparam int PLANNED_CYCLES = 920;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pslverr;
  logic [7:0]  stage_lines;  // spmm vld, spmm rdy, dmvm vld, dmvm rdy, sm ..., aggr rdy.
  logic [13:0] wh_addr;
  logic [11:0] pe_data;
  logic [15:0] feat_addr;
  logic [31:0] feat_data;
  logic        feat_en;
  logic        stage_rand;
  logic        stream_rand;
  logic [13:0] wh_base;
  logic [15:0] feat_base;
  int          seed;
  int          sb_checks;
  int          sb_errors;
  int          err_mark;
  int          chk_mark;
  int          total_errors;

  always #(CLK_PERIOD / 2) clk = ~clk;

  dbg_top dut0 (
    .clk (clk), .rst_n (rst_n),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (), .pslverr_o (pslverr),
    .spmm_vld_i (stage_lines[7]), .spmm_rdy_i (stage_lines[6]),
    .dmvm_vld_i (stage_lines[5]), .dmvm_rdy_i (stage_lines[4]),
    .sm_vld_i (stage_lines[3]), .sm_rdy_i (stage_lines[2]),
    .aggr_vld_i (stage_lines[1]), .aggr_rdy_i (stage_lines[0]),
    .wh_addr_i (wh_addr), .pe_data_i (pe_data),
    .feat_addr_i (feat_addr), .feat_data_i (feat_data), .feat_en_i (feat_en)
  );

  dbg_scoreboard sb0 (
    .clk (clk), .rst_n (rst_n),
    .paddr_i (paddr), .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
    .pwdata_i (pwdata), .prdata_i (prdata), .pslverr_i (pslverr),
    .stage_lines_i (stage_lines), .wh_addr_i (wh_addr), .pe_data_i (pe_data),
    .feat_addr_i (feat_addr), .feat_data_i (feat_data), .feat_en_i (feat_en),
    .checks_o (sb_checks), .errors_o (sb_errors)
  );

  bind dbg_top dbg_checker chk0 (
    .clk (clk), .rst_n (rst_n), .psel_i (psel_i), .penable_i (penable_i),
    .pwrite_i (pwrite_i), .prdata_o (prdata_o), .pready_o (pready_o), .pslverr_o (pslverr_o)
  );

  // Each transfer starts 5 ns after an edge and ends at the same phase two edges later.
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    paddr   = addr;
    pwrite  = 1'b1;
    pwdata  = data;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    penable = 1'b1;
    @(posedge clk);
    #DRIVE_DELAY;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  task automatic read_all_regs();
    for (int a = 0; a <= 32; a += 4) begin
      apb_read(8'(a));
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    int chks;
    errs = sb_errors + dut0.chk0.fails - err_mark;
    chks = sb_checks - chk_mark;
    if (errs == 0) begin
      $display("[%0t] test %-13s ok, %0d checks", $time, name, chks);
    end else begin
      $display("[%0t] test %-13s failed, %0d errors in %0d checks", $time, name, errs, chks);
    end
    err_mark = sb_errors + dut0.chk0.fails;
    chk_mark = sb_checks;
  endtask

  // Enables are taken at the edge so that the test process can flip them without a race.
  always @(posedge clk) begin : traffic
    logic        stage_en;
    logic        stream_en;
    logic [31:0] r;
    stage_en  = stage_rand;
    stream_en = stream_rand;
    #DRIVE_DELAY;
    if (stage_en) begin
      r = $random(seed);
      stage_lines = r[7:0];
    end
    if (stream_en) begin
      r = $random(seed);
      wh_addr   = wh_base + 14'(r[1:0]);  // One address in four hits the match.
      pe_data   = r[27:16];
      feat_en   = r[2];
      feat_addr = feat_base + 16'(r[4:3]);
      feat_data = $random(seed);
    end
  end

  initial begin
    seed        = 32'h6e280c3c;
    rst_n       = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    stage_lines = '0;
    wh_addr     = '0;
    pe_data     = '0;
    feat_addr   = '0;
    feat_data   = '0;
    feat_en     = 1'b0;
    stage_rand  = 1'b0;
    stream_rand = 1'b0;
    wh_base     = '0;
    feat_base   = '0;
    err_mark    = 0;
    chk_mark    = 0;
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    read_all_regs();
    apb_read(8'h24);
    apb_read(8'h02);
    apb_read(8'hFC);
    apb_write(dbg_pkg::REG_ID, 32'hFFFF_FFFF);
    apb_write(dbg_pkg::REG_FLAGS, 32'hFFFF_FFFF);
    apb_write(dbg_pkg::REG_COUNTS, 32'hFFFF_FFFF);
    apb_write(8'h40, 32'hFFFF_FFFF);
    read_all_regs();
    end_test("reset_map");

    stage_rand = 1'b1;
    repeat (10) begin
      idle(26);
      apb_read(dbg_pkg::REG_FLAGS);
      apb_read(dbg_pkg::REG_COUNTS);
    end
    end_test("stage_random");

    stage_rand = 1'b0;
    idle(1);
    stage_lines = 8'b0000_1100;  // sm valid and ready only.
    idle(300);
    apb_read(dbg_pkg::REG_COUNTS);
    apb_read(dbg_pkg::REG_FLAGS);
    end_test("sm_saturate");

    stage_lines = '0;
    apb_write(dbg_pkg::REG_CTRL, 32'h1);
    apb_write(dbg_pkg::REG_WH_MATCH, 32'hFFFF_EA51);
    apb_write(dbg_pkg::REG_FEAT_MATCH, 32'h0000_C0DE);
    read_all_regs();
    wh_base     = 14'h2A50;
    feat_base   = 16'hC0DD;
    stage_rand  = 1'b1;
    stream_rand = 1'b1;
    repeat (10) begin
      idle(14);
      apb_read(dbg_pkg::REG_HITS);
      apb_read(dbg_pkg::REG_WH_DATA);
      apb_read(dbg_pkg::REG_FEAT_DATA);
    end
    end_test("capture");

    // Traffic keeps running while the clear lands.
    apb_write(dbg_pkg::REG_CTRL, 32'h1);
    apb_read(dbg_pkg::REG_FLAGS);
    apb_read(dbg_pkg::REG_COUNTS);
    stage_rand  = 1'b0;
    stream_rand = 1'b0;
    idle(1);
    stage_lines = '0;
    feat_en     = 1'b0;
    apb_write(dbg_pkg::REG_CTRL, 32'h1);
    read_all_regs();
    end_test("clear");

    total_errors = sb_errors + dut0.chk0.fails;
    $display("Summary: %0d checks, %0d errors", sb_checks, total_errors);
    if (total_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(2 * PLANNED_CYCLES * CLK_PERIOD);
    $display("Timeout: test sequence still running after %0d cycles", 2 * PLANNED_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* filelist.f */
dbg_pkg.sv
stage_monitor.sv
sample_capture.sv
dbg_apb_regs.sv
dbg_top.sv
dbg_checker.sv
dbg_scoreboard.sv
dbg_tb.sv

/* Bender.yml */
package:
  name: dbg_observe

sources:
  - files:
      - dbg_pkg.sv
      - stage_monitor.sv
      - sample_capture.sv
      - dbg_apb_regs.sv
      - dbg_top.sv
  - target: test
    files:
      - dbg_checker.sv
      - dbg_scoreboard.sv
      - dbg_tb.sv
